//--- src/mem_pkg.sv
/*
 * Shared definitions for the memory subsystem.
 * Cache geometry, address fields, bus word and line types, and the
 * address slicing helpers used by both caches.
 */

`default_nettype none

package mem_pkg;

	localparam int NUM_LINES      = 16;
	localparam int WORDS_PER_LINE = 16;
	localparam int SRAM_WORDS     = 4096;
	localparam int SRAM_ADDR_BITS = $clog2(SRAM_WORDS);

	// Address split: [31 tag 10] [9 line 6] [5 word 2] [1 byte 0].
	localparam int TAG_LSB  = 10;
	localparam int LINE_LSB = 6;
	localparam int WORD_LSB = 2;

	typedef logic [31:0]                word_t;
	typedef logic [31:TAG_LSB]          tag_t;
	typedef logic [3:0]                 line_idx_t;
	typedef logic [3:0]                 word_idx_t;
	typedef word_t [WORDS_PER_LINE-1:0] line_t;

	// Bus owner, 0 is the instruction cache.
	typedef logic master_sel_t;
	localparam master_sel_t MASTER_I = 1'b0;
	localparam master_sel_t MASTER_D = 1'b1;

	function automatic tag_t addr_tag(input word_t a);
		return a[31:TAG_LSB];
	endfunction

	function automatic line_idx_t addr_line(input word_t a);
		return a[TAG_LSB-1:LINE_LSB];
	endfunction

	function automatic word_idx_t addr_word(input word_t a);
		return a[LINE_LSB-1:WORD_LSB];
	endfunction

	function automatic word_t line_base(input word_t a);
		return {a[31:LINE_LSB], {LINE_LSB{1'b0}}};
	endfunction

endpackage

`default_nettype wire

//--- src/mem_bus_if.sv
/*
 * One master port of the internal memory bus.
 * The cache drives the command through the master modport, the arbiter
 * answers through the slave modport.
 */

`default_nettype none

interface mem_bus_if
	import mem_pkg::*;
();

	// Master side.
	logic  req;
	logic  rd;
	logic  wr;
	word_t addr;
	word_t wdata;

	// Arbiter and slave side.
	logic  ack;
	logic  ready;
	word_t rdata;

	modport master (output req, rd, wr, addr, wdata, input ack, ready, rdata);
	modport slave (input req, rd, wr, addr, wdata, output ack, ready, rdata);
	modport monitor (input req, rd, wr, addr, wdata, ack, ready, rdata);

endinterface

`default_nettype wire

//--- src/icache.sv
/*
 * Direct-mapped read-only instruction cache on the core fetch port.
 * Same lookup and line fill as the data cache. It does not see data
 * writes, so a present line keeps its contents until it is replaced.
 */

`default_nettype none

module icache
	import mem_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  word_t     addr,
	input  logic      rd_req,
	output logic      rd_wait,
	output word_t     rd_data,
	mem_bus_if.master bus
);

	logic [NUM_LINES-1:0] valid;
	tag_t                 tag_mem [NUM_LINES];
	line_t                data_mem [NUM_LINES];

	word_idx_t fill_pos;
	word_t     prev_line;

	line_idx_t idx;
	logic      hit;
	logic      miss;
	logic      fill_restart;
	logic      fill_store;
	logic      fill_last;

	assign idx  = addr_line(addr);
	assign hit  = valid[idx] && (tag_mem[idx] == addr_tag(addr));
	assign miss = rd_req && !hit;

	assign fill_restart = (fill_pos != '0) && (!miss || (prev_line != line_base(addr)));
	assign fill_store   = miss && !fill_restart && bus.ack && bus.ready;
	assign fill_last    = (fill_pos == word_idx_t'(WORDS_PER_LINE - 1));

	assign rd_wait = miss;
	assign rd_data = data_mem[idx][addr_word(addr)];

	// Fetch side never writes.
	assign bus.req   = miss;
	assign bus.rd    = miss && bus.ack;
	assign bus.wr    = 1'b0;
	assign bus.wdata = '0;
	assign bus.addr  = bus.rd ? (line_base(addr) | word_t'({fill_pos, 2'b00})) : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid     <= '0;
			fill_pos  <= '0;
			prev_line <= '0;
		end else begin
			prev_line <= line_base(addr);
			if (fill_restart) begin
				fill_pos <= '0;
			end else if (fill_store) begin
				fill_pos   <= fill_pos + word_idx_t'(1);
				valid[idx] <= fill_last;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill_store) begin
			data_mem[idx][fill_pos] <= bus.rdata;
			if (fill_last) begin
				tag_mem[idx] <= addr_tag(addr);
			end
		end
	end

endmodule

`default_nettype wire

//--- src/dcache.sv
/*
 * Direct-mapped write-through data cache on the core data port.
 * A read hit returns in the same cycle; a read miss fills the whole line
 * one word per bus transfer. Writes always go to memory and also update
 * the cached word when the line is present.
 */

`default_nettype none

module dcache
	import mem_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  word_t     addr,
	input  logic      rd_req,
	input  logic      wr_req,
	input  word_t     wr_data,
	output logic      rd_wait,
	output word_t     rd_data,
	mem_bus_if.master bus
);

	// ********************
	// Line storage
	// ********************
	logic [NUM_LINES-1:0] valid;
	tag_t                 tag_mem [NUM_LINES];
	line_t                data_mem [NUM_LINES];

	word_idx_t fill_pos;
	word_t     prev_line;

	tag_t      tag;
	line_idx_t idx;
	word_idx_t word_sel;
	logic      hit;
	logic      fill_active;
	logic      fill_restart;
	logic      fill_store;
	logic      fill_last;
	logic      wr_done;

	assign tag      = addr_tag(addr);
	assign idx      = addr_line(addr);
	assign word_sel = addr_word(addr);
	assign hit      = valid[idx] && (tag_mem[idx] == tag);

	assign fill_active = rd_req && !hit;
	// Core left the line, or the miss went away.
	assign fill_restart = (fill_pos != '0) &&
		(!fill_active || (prev_line != line_base(addr)));
	assign fill_store = fill_active && !fill_restart && bus.ack && bus.ready;
	assign fill_last  = (fill_pos == word_idx_t'(WORDS_PER_LINE - 1));
	assign wr_done    = wr_req && !fill_active && bus.ack && bus.ready;

	assign rd_wait = fill_active || (wr_req && !wr_done);
	assign rd_data = data_mem[idx][word_sel];

	// ********************
	// Bus command
	// ********************
	always_comb begin
		bus.req   = fill_active || wr_req;
		bus.rd    = 1'b0;
		bus.wr    = 1'b0;
		bus.addr  = '0;
		bus.wdata = '0;
		if (fill_active && bus.ack) begin
			// One word per transfer.
			bus.rd   = 1'b1;
			bus.addr = line_base(addr) | word_t'({fill_pos, 2'b00});
		end else if (wr_req && bus.ack) begin
			bus.wr    = 1'b1;
			bus.addr  = addr;
			bus.wdata = wr_data;
		end
	end

	// ********************
	// Fill control
	// ********************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid     <= '0;
			fill_pos  <= '0;
			prev_line <= '0;
		end else begin
			prev_line <= line_base(addr);
			if (fill_restart) begin
				fill_pos <= '0;
			end else if (fill_store) begin
				fill_pos <= fill_pos + word_idx_t'(1);
				// Line goes invalid while refilling and valid on the last word.
				valid[idx] <= fill_last;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill_store) begin
			data_mem[idx][fill_pos] <= bus.rdata;
			if (fill_last) begin
				tag_mem[idx] <= tag;
			end
		end else if (wr_done && hit) begin
			// Write-through update of a present line.
			data_mem[idx][word_sel] <= wr_data;
		end
	end

endmodule

`default_nettype wire

//--- src/bus_arbiter.sv
/*
 * Arbiter for the single memory bus shared by the two caches.
 * The grant is registered and held while the owner keeps requesting.
 * When the bus goes idle it parks on the master that was not served last.
 */

`default_nettype none

module bus_arbiter
	import mem_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	mem_bus_if.slave ibus,
	mem_bus_if.slave dbus,
	output word_t    mem_addr,
	output logic     mem_rd,
	output logic     mem_wr,
	output word_t    mem_wdata,
	input  word_t    mem_rdata,
	input  logic     mem_ready
);

	master_sel_t owner;
	master_sel_t last_owner;
	logic        sel_i;
	logic        owner_req;
	logic        other_req;

	assign sel_i     = (owner == MASTER_I);
	assign owner_req = sel_i ? ibus.req : dbus.req;
	assign other_req = sel_i ? dbus.req : ibus.req;

	// ********************
	// Grant register
	// ********************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			owner      <= MASTER_I;
			last_owner <= MASTER_D;
		end else if (owner_req) begin
			last_owner <= owner;
		end else if (other_req) begin
			owner <= ~owner;
		end else begin
			// Idle, so park on the master not served last.
			owner <= ~last_owner;
		end
	end

	assign ibus.ack = sel_i && ibus.req;
	assign dbus.ack = !sel_i && dbus.req;

	// Command from the owner only.
	assign mem_addr  = sel_i ? ibus.addr : dbus.addr;
	assign mem_rd    = sel_i ? ibus.rd : dbus.rd;
	assign mem_wr    = sel_i ? ibus.wr : dbus.wr;
	assign mem_wdata = sel_i ? ibus.wdata : dbus.wdata;

	// Responses go back to the owner only.
	assign ibus.rdata = sel_i ? mem_rdata : '0;
	assign ibus.ready = sel_i && mem_ready;
	assign dbus.rdata = sel_i ? '0 : mem_rdata;
	assign dbus.ready = !sel_i && mem_ready;

endmodule

`default_nettype wire

//--- src/sram_ctrl.sv
/*
 * On-chip SRAM, the only slave on the memory bus.
 * Every access takes one wait state, so ready rises in its second cycle.
 * Read data comes straight from the array; writes land at the ready edge.
 */

`default_nettype none

module sram_ctrl
	import mem_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  word_t mem_addr,
	input  logic  mem_rd,
	input  logic  mem_wr,
	input  word_t mem_wdata,
	output word_t mem_rdata,
	output logic  mem_ready
);

	word_t ram [SRAM_WORDS];

	logic                      access;
	logic                      wait_done;
	logic [SRAM_ADDR_BITS-1:0] ram_idx;

	assign access = mem_rd || mem_wr;
	// Low 16 KB only, upper bits ignored.
	assign ram_idx = mem_addr[SRAM_ADDR_BITS+1:2];

	// ********************
	// Wait state
	// ********************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wait_done <= 1'b0;
		end else begin
			// Set in the first cycle, cleared after the ready cycle.
			wait_done <= access && !wait_done;
		end
	end

	assign mem_ready = wait_done && access;
	assign mem_rdata = ram[ram_idx];

	always_ff @(posedge clk) begin
		if (mem_wr && mem_ready) begin
			ram[ram_idx] <= mem_wdata;
		end
	end

endmodule

`default_nettype wire

//--- src/mem_subsys_top.sv
/*
 * Memory subsystem top level.
 * Connects the instruction and data caches to the arbiter and the SRAM,
 * and exposes plain fetch and data ports to the core.
 */

`default_nettype none

module mem_subsys_top
	import mem_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,

	// Fetch port.
	input  word_t i_addr,
	input  logic  i_rd_req,
	output logic  i_wait,
	output word_t i_rd_data,

	// Data port.
	input  word_t d_addr,
	input  logic  d_rd_req,
	input  logic  d_wr_req,
	input  word_t d_wr_data,
	output logic  d_wait,
	output word_t d_rd_data
);

	mem_bus_if ibus ();
	mem_bus_if dbus ();

	// ********************
	// SRAM side of the bus
	// ********************
	word_t mem_addr;
	word_t mem_wdata;
	word_t mem_rdata;
	logic  mem_rd;
	logic  mem_wr;
	logic  mem_ready;

	icache u_icache (
		.clk     (clk),
		.rst_n   (rst_n),
		.addr    (i_addr),
		.rd_req  (i_rd_req),
		.rd_wait (i_wait),
		.rd_data (i_rd_data),
		.bus     (ibus.master)
	);

	dcache u_dcache (
		.clk     (clk),
		.rst_n   (rst_n),
		.addr    (d_addr),
		.rd_req  (d_rd_req),
		.wr_req  (d_wr_req),
		.wr_data (d_wr_data),
		.rd_wait (d_wait),
		.rd_data (d_rd_data),
		.bus     (dbus.master)
	);

	bus_arbiter u_arbiter (
		.clk       (clk),
		.rst_n     (rst_n),
		.ibus      (ibus.slave),
		.dbus      (dbus.slave),
		.mem_addr  (mem_addr),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_ready (mem_ready)
	);

	sram_ctrl u_sram (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_addr  (mem_addr),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_ready (mem_ready)
	);

endmodule

`default_nettype wire

//--- verification/tb_checks.svh
/*
 * Compare tasks for the memory subsystem testbench.
 * Included inside the testbench module; each call counts one check
 * and reports a mismatch with the time and both values.
 */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_word(input string name, input word_t got, input word_t exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
	end
endtask

// Wait in the first cycle is low for a hit and high for a miss or a write.
task automatic check_hit(input string name, input logic exp_hit, input logic first_wait);
	check_count++;
	if (first_wait !== !exp_hit) begin
		error_count++;
		$display("CHECK FAILED at %0d ns: %s in first cycle got %b expected %b",
			$time, name, first_wait, !exp_hit);
	end
endtask

`endif

//--- verification/tb_mem_subsys.sv
/*
 * Testbench for the memory subsystem top level.
 * Runs the operations of the trace file on the fetch and data ports,
 * then a random mix of fetches and data writes checked against a model.
 */

`default_nettype none

module tb_mem_subsys
	import mem_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 200;
	localparam int RANDOM_OPS     = 60;

	logic  clk;
	logic  rst_n;
	word_t i_addr;
	logic  i_rd_req;
	logic  i_wait;
	word_t i_rd_data;
	word_t d_addr;
	logic  d_rd_req;
	logic  d_wr_req;
	word_t d_wr_data;
	logic  d_wait;
	word_t d_rd_data;

	int   error_count;
	int   check_count;
	int   test_count;
	int   failed_tests;
	logic timed_out;

	// ********************
	// Reference model
	// ********************
	word_t mem_model [int];
	logic  ic_valid [NUM_LINES];
	tag_t  ic_tag [NUM_LINES];
	word_t ic_line [NUM_LINES][WORDS_PER_LINE];

	mem_subsys_top dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_addr    (i_addr),
		.i_rd_req  (i_rd_req),
		.i_wait    (i_wait),
		.i_rd_data (i_rd_data),
		.d_addr    (d_addr),
		.d_rd_req  (d_rd_req),
		.d_wr_req  (d_wr_req),
		.d_wr_data (d_wr_data),
		.d_wait    (d_wait),
		.d_rd_data (d_rd_data)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	// SRAM word slot. The low 16 KB alias over the whole address space.
	function automatic int word_key(input word_t a);
		return int'(a[13:2]);
	endfunction

	function automatic void write_model(input word_t a, input word_t v);
		mem_model[word_key(a)] = v;
	endfunction

	// Fetch through the model cache. A miss copies the line from memory.
	function automatic word_t fetch_model(input word_t a, output logic hit);
		int idx;
		int base;
		int w;
		idx  = int'(a[9:6]);
		base = word_key({a[31:6], 6'b000000});
		hit  = ic_valid[idx] && (ic_tag[idx] == a[31:10]);
		if (!hit) begin
			for (w = 0; w < WORDS_PER_LINE; w++) begin
				ic_line[idx][w] = mem_model.exists(base + w) ? mem_model[base + w] : '0;
			end
			ic_valid[idx] = 1'b1;
			ic_tag[idx]   = a[31:10];
		end
		return ic_line[idx][a[5:2]];
	endfunction

	// ********************
	// Port driver
	// ********************
	task automatic run_op(input logic on_d, input logic is_wr, input word_t addr,
			input word_t value, input logic exp_hit);
		int    cycles;
		logic  first_wait;
		logic  busy;
		string wait_name;
		string data_name;
		wait_name = on_d ? "d_wait" : "i_wait";
		data_name = on_d ? "d_rd_data" : "i_rd_data";
		@(posedge clk);
		#5;
		if (on_d) begin
			d_addr    = addr;
			d_wr_data = is_wr ? value : '0;
			d_rd_req  = !is_wr;
			d_wr_req  = is_wr;
		end else begin
			i_addr   = addr;
			i_rd_req = 1'b1;
		end
		@(negedge clk);
		first_wait = on_d ? d_wait : i_wait;
		busy       = first_wait;
		cycles     = 0;
		while (busy && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
			busy = on_d ? d_wait : i_wait;
		end
		if (busy) begin
			$display("ERROR: access to address %h on %s did not finish within %0d cycles",
				addr, wait_name, TIMEOUT_CYCLES);
			error_count++;
			timed_out = 1'b1;
		end else begin
			check_hit(wait_name, exp_hit, first_wait);
			if (!is_wr) begin
				check_word(data_name, on_d ? d_rd_data : i_rd_data, value);
			end
		end
		@(posedge clk);
		#5;
		if (on_d) begin
			d_rd_req = 1'b0;
			d_wr_req = 1'b0;
		end else begin
			i_rd_req = 1'b0;
		end
	endtask

	task automatic report_test(input string what, input int errs_before);
		test_count++;
		if (error_count == errs_before) begin
			$display("test %0d %s: ok", test_count, what);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d error(s)", test_count, what, error_count - errs_before);
		end
	endtask

	// ********************
	// Trace phase
	// ********************
	task automatic run_trace();
		int               fd;
		int               n;
		int               r;
		int               hit_flag;
		int               errs_before;
		logic             parse_ok;
		logic             hit_model;
		logic             on_d;
		logic             is_wr;
		string            port_tok;
		string            op_tok;
		logic [8*128-1:0] rest;
		word_t            addr;
		word_t            value;
		word_t            model_val;
		fd = $fopen("verification/mem_trace.txt", "r");
		if (fd == 0) begin
			$display("ERROR: the trace file verification/mem_trace.txt could not be opened");
			error_count++;
		end else begin
			parse_ok = 1'b1;
			n = $fscanf(fd, "%s", port_tok);
			while (n == 1 && parse_ok && !timed_out) begin
				if (port_tok == "#") begin
					r = $fgets(rest, fd);
				end else begin
					r = $fscanf(fd, "%s %h %h %d", op_tok, addr, value, hit_flag);
					if (r != 4 || !(port_tok == "i" || port_tok == "d")) begin
						$display("ERROR: the trace has a malformed line starting with %s", port_tok);
						error_count++;
						parse_ok = 1'b0;
					end else begin
						on_d        = (port_tok == "d");
						is_wr       = (op_tok == "write");
						errs_before = error_count;
						if (is_wr) begin
							write_model(addr, value);
						end else if (!on_d) begin
							model_val = fetch_model(addr, hit_model);
							if (model_val !== value || hit_model !== (hit_flag != 0)) begin
								$display("ERROR: the trace line for the fetch at %h disagrees with the fetch model",
									addr);
								error_count++;
							end
						end
						run_op(on_d, is_wr, addr, value, hit_flag != 0);
						report_test($sformatf("%s %s %h", port_tok, op_tok, addr), errs_before);
					end
				end
				n = $fscanf(fd, "%s", port_tok);
			end
			$fclose(fd);
		end
	endtask

	// ********************
	// Random phase
	// ********************
	task automatic run_random();
		word_t bases [4];
		int    errs_before;
		int    i;
		int    kind;
		int    rl;
		int    wl;
		word_t ra;
		word_t wa;
		word_t wv;
		word_t rexp;
		logic  rhit;
		// Two indices with two tags each.
		bases = '{32'h0000_0200, 32'h0000_0600, 32'h0000_0240, 32'h0000_0a40};
		errs_before = error_count;
		for (rl = 0; rl < 4 && !timed_out; rl++) begin
			for (i = 0; i < WORDS_PER_LINE && !timed_out; i++) begin
				wa = bases[rl] + word_t'(i * 4);
				wv = $urandom;
				write_model(wa, wv);
				run_op(1'b1, 1'b1, wa, wv, 1'b0);
			end
		end
		report_test("region preload", errs_before);
		errs_before = error_count;
		for (i = 0; i < RANDOM_OPS && !timed_out; i++) begin
			kind = $urandom_range(2, 0);
			rl   = $urandom_range(3, 0);
			wl   = (rl + 1 + $urandom_range(2, 0)) % 4;
			ra   = bases[rl] + word_t'($urandom_range(15, 0) * 4);
			wa   = bases[wl] + word_t'($urandom_range(15, 0) * 4);
			wv   = $urandom;
			case (kind)
				0: begin
					rexp = fetch_model(ra, rhit);
					run_op(1'b0, 1'b0, ra, rexp, rhit);
				end
				1: begin
					write_model(wa, wv);
					run_op(1'b1, 1'b1, wa, wv, 1'b0);
				end
				default: begin
					// Both ports at once on different lines.
					rexp = fetch_model(ra, rhit);
					write_model(wa, wv);
					fork
						run_op(1'b0, 1'b0, ra, rexp, rhit);
						run_op(1'b1, 1'b1, wa, wv, 1'b0);
					join
				end
			endcase
		end
		report_test($sformatf("random mix of %0d operations", i), errs_before);
	endtask

	initial begin
		void'($urandom(72));
		error_count  = 0;
		check_count  = 0;
		test_count   = 0;
		failed_tests = 0;
		timed_out    = 1'b0;
		rst_n        = 1'b0;
		i_addr       = '0;
		i_rd_req     = 1'b0;
		d_addr       = '0;
		d_rd_req     = 1'b0;
		d_wr_req     = 1'b0;
		d_wr_data    = '0;
		for (int k = 0; k < NUM_LINES; k++) begin
			ic_valid[k] = 1'b0;
		end
		repeat (8) @(posedge clk);
		#5 rst_n = 1'b1;
		run_trace();
		if (!timed_out) begin
			run_random();
		end
		$display("Tests run: %0d, tests failed: %0d, checks: %0d, errors: %0d",
			test_count, failed_tests, check_count, error_count);
		if (error_count == 0 && failed_tests == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	`include "tb_checks.svh"

endmodule

`default_nettype wire

//--- flist.f
+incdir+verification
src/mem_pkg.sv
src/mem_bus_if.sv
src/icache.sv
src/dcache.sv
src/bus_arbiter.sv
src/sram_ctrl.sv
src/mem_subsys_top.sv
verification/tb_mem_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the memory subsystem testbench with Verilator and runs it.

set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator was not found on the PATH"
	exit 1
fi

if ! verilator --binary --timescale 1ns/1ps --top-module tb_mem_subsys \
	-f flist.f -o tb_mem_subsys_sim; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_mem_subsys_sim)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi

if grep -qx "Simulation PASSED" <<< "$sim_out"; then
	exit 0
fi
exit 1

//--- verification/mem_trace.txt
# port op addr data hit
# data is the write value or the expected read value, hit 1 means no wait in the first cycle
d write 00000040 11111111 0
d write 00000044 22222222 0
d read 00000040 11111111 0
d read 00000044 22222222 1
d write 00000048 33333333 0
d read 00000048 33333333 1
d write 00000040 44444444 0
d read 00000040 44444444 1
d write 00000080 aaaa0001 0
d write 00000084 aaaa0002 0
i read 00000080 aaaa0001 0
i read 00000084 aaaa0002 1
d write 00000080 bbbb0001 0
i read 00000080 aaaa0001 1
d write 00000480 cccc0001 0
i read 00000480 cccc0001 0
i read 00000080 bbbb0001 0
d read 00000084 aaaa0002 0
d read 00000080 bbbb0001 1
i read 00000040 44444444 0
i read 00000048 33333333 1
d write 00000440 dddd0001 0
d read 00000440 dddd0001 0
d read 00000040 44444444 0
